// ==== design/hdmi_cfg_pkg.sv ====
`default_nettype none

package hdmi_cfg_pkg;

    typedef logic [6:0] mode_code_t;
    typedef logic [3:0] mode_id_t;
    typedef logic [2:0] delay_sel_t;
    typedef logic [1:0] colorspace_t;
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [2:0] step_t;
    typedef logic [2:0] credit_t;

    localparam int NUM_STEPS   = 6;
    localparam int QUEUE_DEPTH = 4;    // also the sequencer's initial credit
    localparam int EXT_CREDITS = 2;    // toward the I2C master
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    typedef logic [QUEUE_PTR_W-1:0] queue_ptr_t;
    typedef logic [QUEUE_PTR_W:0]   queue_count_t;

    // decoded video modes
    localparam mode_id_t MODE_1080P      = 4'd0;
    localparam mode_id_t MODE_960P       = 4'd1;
    localparam mode_id_t MODE_480P       = 4'd2;
    localparam mode_id_t MODE_VGA        = 4'd3;
    localparam mode_id_t MODE_576P       = 4'd4;
    localparam mode_id_t MODE_240P_1080P = 4'd5;
    localparam mode_id_t MODE_240P_960P  = 4'd6;
    localparam mode_id_t MODE_240P_480P  = 4'd7;
    localparam mode_id_t MODE_240P_VGA   = 4'd8;
    localparam mode_id_t MODE_480I       = 4'd9;
    localparam mode_id_t MODE_576I       = 4'd10;

    // transmitter registers
    localparam reg_addr_t ADDR_VIC    = 8'h3C;
    localparam reg_addr_t ADDR_PIXREP = 8'h3B;
    localparam reg_addr_t ADDR_SYNC   = 8'h17;
    localparam reg_addr_t ADDR_AVI    = 8'h55;
    localparam reg_addr_t ADDR_OUTFMT = 8'h16;
    localparam reg_addr_t ADDR_CLKDLY = 8'hBA;

    localparam mode_id_t    RESET_MODE       = MODE_1080P;
    localparam mode_code_t  RESET_MODE_CODE  = 7'h00;    // host code of 1080P
    localparam delay_sel_t  RESET_DELAY      = 3'd3;     // no clock delay
    localparam colorspace_t RESET_COLORSPACE = 2'd0;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WAIT_CREDIT
    } seq_state_t;

endpackage

`default_nettype wire

// ==== design/cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface reconf_if
    import hdmi_cfg_pkg::*;
();
    logic        req;         // one-cycle pulse
    mode_id_t    mode;
    delay_sel_t  delay;
    colorspace_t colorspace;
    logic        pending;     // change seen, req follows next cycle

    modport source (output req, output mode, output delay, output colorspace, output pending);
    modport sink   (input req, input mode, input delay, input colorspace, input pending);
endinterface

interface cfg_write_if
    import hdmi_cfg_pkg::*;
();
    logic      valid;
    reg_addr_t addr;
    reg_data_t data;
    logic      credit_ret;    // one pulse per entry leaving the queue

    modport source (output valid, output addr, output data, input credit_ret);
    modport sink   (input valid, input addr, input data, output credit_ret);
endinterface

`default_nettype wire

// ==== design/mode_change_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module mode_change_detect
    import hdmi_cfg_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire mode_code_t  mode_code,
    input  wire delay_sel_t  delay_sel,
    input  wire colorspace_t colorspace,
    reconf_if.source         reconf
);

    mode_code_t  held_code;
    delay_sel_t  held_delay;
    colorspace_t held_cs;
    logic        init_q;      // owes the request after reset
    logic        req_q;
    mode_id_t    mode_q;
    delay_sel_t  delay_q;
    colorspace_t cs_q;
    logic        change;

    // unknown codes keep the previous mode
    function automatic mode_id_t decode_mode(input mode_code_t code, input mode_id_t prev);
        mode_id_t result;
        result = prev;
        case (code[6:2])
            5'b00000: result = mode_id_t'(MODE_1080P + code[1:0]);
            5'b00010: result = MODE_576P;
            5'b00100: result = mode_id_t'(MODE_240P_1080P + code[1:0]);
            5'b01000: result = MODE_480I;
            5'b10000: result = MODE_576I;
            default:  result = prev;
        endcase
        return result;
    endfunction

    assign change = (mode_code != held_code) || (delay_sel != held_delay)
                 || (colorspace != held_cs);

    always_ff @(posedge clock) begin
        if (reset) begin
            held_code  <= RESET_MODE_CODE;
            held_delay <= RESET_DELAY;
            held_cs    <= RESET_COLORSPACE;
            init_q     <= 1'b1;
            req_q      <= 1'b0;
            mode_q     <= RESET_MODE;
            delay_q    <= RESET_DELAY;
            cs_q       <= RESET_COLORSPACE;
        end else begin
            held_code  <= mode_code;
            held_delay <= delay_sel;
            held_cs    <= colorspace;
            init_q     <= 1'b0;
            req_q      <= change || init_q;
            if (change) begin
                if (mode_code != held_code) begin
                    mode_q <= decode_mode(mode_code, mode_q);
                end
                delay_q <= delay_sel;
                cs_q    <= colorspace;
            end
        end
    end

    assign reconf.req        = req_q;
    assign reconf.mode       = mode_q;
    assign reconf.delay      = delay_q;
    assign reconf.colorspace = cs_q;
    assign reconf.pending    = change;

endmodule

`default_nettype wire

// ==== design/mode_reg_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module mode_reg_table
    import hdmi_cfg_pkg::*;
(
    input  wire mode_id_t    mode,
    input  wire delay_sel_t  delay,
    input  wire colorspace_t colorspace,
    input  wire step_t       step,
    output reg_addr_t        addr,
    output reg_data_t        data
);

    reg_data_t vic;
    reg_data_t pixrep;
    reg_data_t sync;

    always_comb begin
        case (mode)
            MODE_1080P, MODE_240P_1080P: vic = 8'd16;
            MODE_960P, MODE_240P_960P:   vic = 8'd0;
            MODE_480P, MODE_240P_480P:   vic = 8'd2;
            MODE_VGA, MODE_240P_VGA:     vic = 8'd1;
            MODE_576P:                   vic = 8'd17;
            MODE_480I:                   vic = 8'd6;
            MODE_576I:                   vic = 8'd21;
            default:                     vic = 8'd16;
        endcase

        // 240P and interlaced modes send every pixel twice
        pixrep = (mode >= MODE_240P_1080P && mode <= MODE_576I) ? 8'h01 : 8'h00;

        case (mode)
            MODE_480P, MODE_VGA, MODE_576P, MODE_480I, MODE_576I: sync = 8'h02;    // negative
            default: sync = 8'h00;
        endcase
    end

    always_comb begin
        case (step)
            3'd0: begin
                addr = ADDR_VIC;
                data = vic;
            end
            3'd1: begin
                addr = ADDR_PIXREP;
                data = pixrep;
            end
            3'd2: begin
                addr = ADDR_SYNC;
                data = sync;
            end
            3'd3: begin
                addr = ADDR_AVI;
                data = {1'b0, colorspace, 5'b0};
            end
            3'd4: begin
                addr = ADDR_OUTFMT;
                data = (colorspace != 2'd0) ? 8'h01 : 8'h00;
            end
            3'd5: begin
                addr = ADDR_CLKDLY;
                data = {delay, 5'b0};
            end
            default: begin
                addr = 8'h00;
                data = 8'h00;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_sequencer
    import hdmi_cfg_pkg::*;
(
    input  wire logic   clock,
    input  wire logic   reset,
    reconf_if.sink      reconf,
    cfg_write_if.source wr,
    output logic        busy
);

    seq_state_t  state;
    step_t       step_q;
    credit_t     credit_q;
    credit_t     credit_next;
    logic        pend_q;      // request seen mid-sequence
    logic        last_step;
    logic        start;
    mode_id_t    mode_q;
    delay_sel_t  delay_q;
    colorspace_t cs_q;

    mode_reg_table i_table (
        .mode       (mode_q),
        .delay      (delay_q),
        .colorspace (cs_q),
        .step       (step_q),
        .addr       (wr.addr),
        .data       (wr.data)
    );

    assign wr.valid    = (state == WRITE);
    assign last_step   = (step_q == step_t'(NUM_STEPS - 1));
    assign credit_next = credit_q - credit_t'(wr.valid) + credit_t'(wr.credit_ret);

    // a new sequence begins after this cycle
    assign start = ((state == IDLE) && reconf.req)
                || (wr.valid && last_step && (pend_q || reconf.req));

    assign busy = (state != IDLE) || reconf.req || reconf.pending;

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= IDLE;
            step_q   <= '0;
            credit_q <= credit_t'(QUEUE_DEPTH);
            pend_q   <= 1'b0;
        end else begin
            credit_q <= credit_next;
            case (state)
                IDLE: begin
                    if (start) begin
                        step_q <= '0;
                        state  <= (credit_next != '0) ? WRITE : WAIT_CREDIT;
                    end
                end
                WRITE: begin
                    if (!last_step) begin
                        step_q <= step_q + step_t'(1);
                        state  <= (credit_next != '0) ? WRITE : WAIT_CREDIT;
                    end else if (start) begin
                        step_q <= '0;    // back to back sequence
                        state  <= (credit_next != '0) ? WRITE : WAIT_CREDIT;
                    end else begin
                        state <= IDLE;
                    end
                end
                WAIT_CREDIT: begin
                    if (wr.credit_ret) begin
                        state <= WRITE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (start) begin
                pend_q <= 1'b0;
            end else if (reconf.req && state != IDLE) begin
                pend_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            mode_q  <= reconf.mode;
            delay_q <= reconf.delay;
            cs_q    <= reconf.colorspace;
        end
    end

endmodule

`default_nettype wire

// ==== design/write_credit_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module write_credit_queue
    import hdmi_cfg_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  reset,
    cfg_write_if.sink  wr,
    input  wire logic  wr_credit,
    output logic       wr_valid,
    output reg_addr_t  wr_addr,
    output reg_data_t  wr_data,
    output logic       pending
);

    reg_addr_t    addr_mem [QUEUE_DEPTH];
    reg_data_t    data_mem [QUEUE_DEPTH];
    queue_ptr_t   wr_ptr;
    queue_ptr_t   rd_ptr;
    queue_count_t count;
    credit_t      ext_credit;
    logic         pop;

    // head leaves whenever the I2C side has room
    assign pop = (count != '0) && (ext_credit != '0);

    assign wr_valid      = pop;
    assign wr_addr       = addr_mem[rd_ptr];
    assign wr_data       = data_mem[rd_ptr];
    assign wr.credit_ret = pop;
    assign pending       = (count != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            ext_credit <= credit_t'(EXT_CREDITS);
        end else begin
            if (wr.valid) begin
                wr_ptr <= wr_ptr + queue_ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + queue_ptr_t'(1);
            end
            count      <= count + queue_count_t'(wr.valid) - queue_count_t'(pop);
            ext_credit <= ext_credit - credit_t'(pop) + credit_t'(wr_credit);
        end
    end

    always_ff @(posedge clock) begin
        if (wr.valid) begin
            addr_mem[wr_ptr] <= wr.addr;
            data_mem[wr_ptr] <= wr.data;
        end
    end

endmodule

`default_nettype wire

// ==== design/hdmi_reconfig_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdmi_reconfig_top
    import hdmi_cfg_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire mode_code_t  mode_code,
    input  wire delay_sel_t  delay_sel,
    input  wire colorspace_t colorspace,
    input  wire logic        wr_credit,
    output logic             wr_valid,
    output reg_addr_t        wr_addr,
    output reg_data_t        wr_data,
    output logic             busy
);

    logic seq_busy;
    logic queue_pending;

    reconf_if    reconf ();
    cfg_write_if cfg_wr ();

    mode_change_detect i_detect (
        .clock      (clock),
        .reset      (reset),
        .mode_code  (mode_code),
        .delay_sel  (delay_sel),
        .colorspace (colorspace),
        .reconf     (reconf.source)
    );

    reg_sequencer i_sequencer (
        .clock  (clock),
        .reset  (reset),
        .reconf (reconf.sink),
        .wr     (cfg_wr.source),
        .busy   (seq_busy)
    );

    write_credit_queue i_queue (
        .clock     (clock),
        .reset     (reset),
        .wr        (cfg_wr.sink),
        .wr_credit (wr_credit),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .pending   (queue_pending)
    );

    assign busy = seq_busy || queue_pending;    // running or still draining

endmodule

`default_nettype wire

// ==== sim/hdmi_reconfig_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdmi_reconfig_assertions
    import hdmi_cfg_pkg::*;
(
    input wire logic         clock,
    input wire logic         reset,
    input wire logic         wr_valid,
    input wire logic         wr_credit,
    input wire queue_count_t count
);

    credit_t free_credit;    // credits held toward the I2C side

    always_ff @(posedge clock) begin
        if (reset) begin
            free_credit <= credit_t'(EXT_CREDITS);
        end else begin
            free_credit <= free_credit - credit_t'(wr_valid) + credit_t'(wr_credit);
        end
    end

    // a write only goes out against a credit from the I2C master
    valid_needs_credit: assert property (
        @(posedge clock) disable iff (reset) wr_valid |-> (free_credit != '0)
    ) else $error("write left the queue with no external credit");

    queue_within_depth: assert property (
        @(posedge clock) disable iff (reset) count <= queue_count_t'(QUEUE_DEPTH)
    ) else $error("queue holds more entries than its depth");

    // checked one cycle on, once reset has taken hold
    quiet_in_reset: assert property (
        @(posedge clock) reset |=> !wr_valid
    ) else $error("write left the queue during reset");

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    localparam int HALF_PERIOD  = 20;    // 40 ns clock
    localparam int RESET_CYCLES = 5;

    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== sim/tb_hdmi_reconfig.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_reconfig
    import hdmi_cfg_pkg::*;
();

    localparam int NUM_SEQUENCES = 29;    // reset, sweep, unlisted, back-pressure, burst
    localparam int CYCLE_LIMIT   = 40 * NUM_SEQUENCES + 200;

    logic        clock;
    logic        reset;
    mode_code_t  mode_code;
    delay_sel_t  delay_sel;
    colorspace_t colorspace;
    logic        wr_credit = 1'b0;
    logic        wr_valid;
    reg_addr_t   wr_addr;
    reg_data_t   wr_data;
    logic        busy;

    reg_addr_t   exp_addr_q[$];
    reg_data_t   exp_data_q[$];
    string       exp_label_q[$];
    int          credit_due[$];       // cycle at which each write's credit goes back
    int          skip_left   = 0;     // writes of a superseded sequence
    int          last_due    = 0;
    int          cycle_count = 0;
    logic [15:0] lfsr_state  = 16'd9;
    logic        hold_long   = 1'b0;
    mode_id_t    ref_mode    = RESET_MODE;
    mode_code_t  cur_code    = RESET_MODE_CODE;
    delay_sel_t  cur_delay   = RESET_DELAY;
    colorspace_t cur_cs      = RESET_COLORSPACE;

    tb_clock_gen i_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    hdmi_reconfig_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .mode_code  (mode_code),
        .delay_sel  (delay_sel),
        .colorspace (colorspace),
        .wr_credit  (wr_credit),
        .wr_valid   (wr_valid),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .busy       (busy)
    );

    bind write_credit_queue hdmi_reconfig_assertions i_queue_assertions (
        .clock      (clock),
        .reset      (reset),
        .wr_valid   (wr_valid),
        .wr_credit  (wr_credit),
        .count      (count)
    );

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic int unsigned take_bits(input int n);
        int unsigned value;
        value = 0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | lfsr_state[0];
        end
        return value;
    endfunction

    function automatic mode_code_t listed_code(input int i);
        int base;
        base = (i < 4) ? 0 : (8 << (i / 4 - 1));    // 0x00, 0x08, 0x10, 0x20, 0x40
        return mode_code_t'(base + i % 4);
    endfunction

    function automatic mode_id_t decode_code(input mode_code_t code, input mode_id_t prev);
        mode_id_t m;
        m = prev;
        if (code <= 7'h03) m = mode_id_t'(code);
        else if (code >= 7'h08 && code <= 7'h0B) m = MODE_576P;
        else if (code >= 7'h10 && code <= 7'h13) m = mode_id_t'(MODE_240P_1080P + code - 7'h10);
        else if (code >= 7'h20 && code <= 7'h23) m = MODE_480I;
        else if (code >= 7'h40 && code <= 7'h43) m = MODE_576I;
        return m;
    endfunction

    function automatic void expected_write(input mode_code_t code, input mode_id_t prev,
            input delay_sel_t delay, input colorspace_t cs, input step_t step,
            output reg_addr_t addr, output reg_data_t data);
        mode_id_t  m;
        reg_data_t vic;
        m = decode_code(code, prev);
        case (m)
            MODE_1080P, MODE_240P_1080P: vic = 8'd16;
            MODE_960P, MODE_240P_960P:   vic = 8'd0;
            MODE_480P, MODE_240P_480P:   vic = 8'd2;
            MODE_VGA, MODE_240P_VGA:     vic = 8'd1;
            MODE_576P:                   vic = 8'd17;
            MODE_480I:                   vic = 8'd6;
            MODE_576I:                   vic = 8'd21;
            default:                     vic = 8'hFF;
        endcase
        case (step)
            3'd0:    addr = ADDR_VIC;
            3'd1:    addr = ADDR_PIXREP;
            3'd2:    addr = ADDR_SYNC;
            3'd3:    addr = ADDR_AVI;
            3'd4:    addr = ADDR_OUTFMT;
            default: addr = ADDR_CLKDLY;
        endcase
        case (step)
            3'd0: data = vic;
            3'd1: data = (m inside {MODE_240P_1080P, MODE_240P_960P, MODE_240P_480P,
                                    MODE_240P_VGA, MODE_480I, MODE_576I}) ? 8'h01 : 8'h00;
            3'd2: data = (m inside {MODE_480P, MODE_VGA, MODE_576P,
                                    MODE_480I, MODE_576I}) ? 8'h02 : 8'h00;
            3'd3: data = reg_data_t'(cs) << 5;
            3'd4: data = (cs != 2'd0) ? 8'h01 : 8'h00;
            default: data = reg_data_t'(delay) << 5;
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s wr_addr 0x%02h, expected 0x%02h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s wr_data 0x%02h, expected 0x%02h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s busy %0b, expected %0b",
                               $time, what, got, exp));
        end
    endtask

    task automatic queue_sequence(input mode_code_t code, input delay_sel_t delay,
            input colorspace_t cs);
        reg_addr_t addr;
        reg_data_t data;
        for (int s = 0; s < NUM_STEPS; s++) begin
            expected_write(code, ref_mode, delay, cs, step_t'(s), addr, data);
            exp_addr_q.push_back(addr);
            exp_data_q.push_back(data);
            exp_label_q.push_back($sformatf("code 0x%02h step %0d", code, s));
        end
        ref_mode = decode_code(code, ref_mode);
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clock);
            if (exp_addr_q.size() != 0 || skip_left != 0) begin
                check_busy(busy, 1'b1, "writes outstanding");    // high until the last write
            end
        end while (exp_addr_q.size() != 0 || skip_left != 0 || busy);
    endtask

    task automatic apply_settings(input mode_code_t code, input delay_sel_t delay,
            input colorspace_t cs, input bit checked);
        bit differs;
        differs = (code != cur_code) || (delay != cur_delay) || (cs != cur_cs);
        @(posedge clock);
        mode_code  <= code;
        delay_sel  <= delay;
        colorspace <= cs;
        cur_code  = code;
        cur_delay = delay;
        cur_cs    = cs;
        if (differs && checked) begin
            queue_sequence(code, delay, cs);
        end else if (differs) begin
            skip_left += NUM_STEPS;    // superseded, still runs in full
            ref_mode = decode_code(code, ref_mode);
        end
        if (checked) begin
            wait_idle();
        end
    endtask

    // I2C master model, finishes writes in order
    always @(posedge clock) begin
        if (reset) begin
            wr_credit <= 1'b0;
        end else begin
            if (wr_valid && (credit_due.size() + int'(wr_credit) >= EXT_CREDITS)) begin
                fail_run("the I2C master got a write while it held no free credit");
            end
            if (credit_due.size() != 0 && credit_due[0] <= cycle_count) begin
                wr_credit <= 1'b1;
                void'(credit_due.pop_front());
            end else begin
                wr_credit <= 1'b0;
            end
            if (wr_valid) begin
                last_due = cycle_count + (hold_long ? 12 + take_bits(4) : 1 + take_bits(3));
                if (credit_due.size() != 0 && last_due <= credit_due[$]) begin
                    last_due = credit_due[$] + 1;
                end
                credit_due.push_back(last_due);
            end
        end
    end

    always @(posedge clock) begin
        if (!reset && wr_valid) begin
            if (skip_left > 0) begin
                skip_left = skip_left - 1;
            end else if (exp_addr_q.size() == 0) begin
                fail_run($sformatf("an extra write to 0x%02h came out with none expected",
                                   wr_addr));
            end else begin
                check_addr(wr_addr, exp_addr_q[0], exp_label_q[0]);
                check_data(wr_data, exp_data_q[0], exp_label_q[0]);
                void'(exp_addr_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_label_q.pop_front());
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run($sformatf("TIMEOUT: the design hung, run not done after %0d cycles",
                               cycle_count));
        end
    end

    initial begin
        mode_code  <= RESET_MODE_CODE;
        delay_sel  <= RESET_DELAY;
        colorspace <= RESET_COLORSPACE;
        queue_sequence(RESET_MODE_CODE, RESET_DELAY, RESET_COLORSPACE);    // after reset
        @(posedge clock);
        while (reset) @(posedge clock);
        wait_idle();

        for (int i = 0; i < 20; i++) begin
            apply_settings(listed_code(i), delay_sel_t'(i % 8), colorspace_t'(i % 4), 1'b1);
        end

        // unknown codes keep 576I
        apply_settings(7'h05, 3'd5, 2'd1, 1'b1);
        apply_settings(7'h7F, 3'd2, 2'd3, 1'b1);

        hold_long = 1'b1;
        apply_settings(7'h12, 3'd7, 2'd2, 1'b1);
        apply_settings(7'h09, 3'd1, 2'd3, 1'b1);
        apply_settings(7'h21, 3'd4, 2'd0, 1'b1);
        apply_settings(7'h03, 3'd6, 2'd1, 1'b1);
        hold_long = 1'b0;

        // second change lands mid-sequence
        apply_settings(7'h10, 3'd2, 2'd1, 1'b0);
        repeat (3) @(posedge clock);
        apply_settings(7'h41, 3'd5, 2'd2, 1'b1);

        repeat (20) @(posedge clock);    // room for a stray write
        if (exp_addr_q.size() != 0 || skip_left != 0) begin
            fail_run("expected writes were still missing at the end of the run");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/hdmi_cfg_pkg.sv
design/cfg_if.sv
design/mode_change_detect.sv
design/mode_reg_table.sv
design/reg_sequencer.sv
design/write_credit_queue.sv
design/hdmi_reconfig_top.sv
sim/hdmi_reconfig_assertions.sv
sim/tb_clock_gen.sv
sim/tb_hdmi_reconfig.sv

// ==== Bender.yml ====
package:
  name: hdmi_reconfig

sources:
  # design
  - files:
      - design/hdmi_cfg_pkg.sv
      - design/cfg_if.sv
      - design/mode_change_detect.sv
      - design/mode_reg_table.sv
      - design/reg_sequencer.sv
      - design/write_credit_queue.sv
      - design/hdmi_reconfig_top.sv

  # testbench
  - target: simulation
    files:
      - sim/hdmi_reconfig_assertions.sv
      - sim/tb_clock_gen.sv
      - sim/tb_hdmi_reconfig.sv
